// ==== verilog/dbg_brk_config.svh ====
//////////////////////////////////////////////////
// Build options and register map of the debug block
// Included by the package and by every RTL module
//////////////////////////////////////////////////

`ifndef DBG_BRK_CONFIG_SVH
`define DBG_BRK_CONFIG_SVH

// Number of break/watch-point units, 1 to 4
`define DBG_HWBRK_NUM    2
// Range mode support, 1 on, 0 off
`define DBG_HWBRK_RANGE  1'b1

// Debug register address width
`define DBG_ADDR_W       6

// CPU register addresses
`define DBG_CPU_CTL      6'h00
`define DBG_CPU_STAT     6'h01
// Unit 0 address, each unit spans four addresses
`define DBG_BRK_BASE     'h08

// Register offsets inside a unit window
`define BRK_CTL          2'd0
`define BRK_STAT         2'd1
`define BRK_ADDR0        2'd2
`define BRK_ADDR1        2'd3

// CPU_CTL command bits
`define CPU_CTL_HALT     0
`define CPU_CTL_RUN      1

// CPU_STAT bits
`define CPU_STAT_HALTED  0
`define CPU_STAT_PND     1
`define CPU_STAT_BRK     2

`endif

// ==== verilog/dbg_brk_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the debug block
// Register port, watched CPU bus, unit ctl and stat
//////////////////////////////////////////////////

`default_nettype none

`include "dbg_brk_config.svh"

package dbg_brk_pkg;

  // Host register request, wr and rd are one-cycle strobes
  typedef struct packed {
    logic [`DBG_ADDR_W-1:0] addr;
    logic [15:0]            din;
    logic                   wr;
    logic                   rd;
  } dbg_req_t;

  // CPU activity seen by the break units
  typedef struct packed {
    // Execution-unit memory bus
    logic [15:0] eu_mab;
    logic        eu_mb_en;
    logic [1:0]  eu_mb_wr;
    // Frontend instruction decode
    logic [15:0] pc;
    logic        decode_noirq;
  } cpu_bus_t;

  // Unit control register, bits 4 to 0
  typedef struct packed {
    logic       range_mode;
    logic       inst_en;
    logic       break_en;
    // 00 off, 01 read, 10 write, 11 both
    logic [1:0] access_mode;
  } brk_ctl_t;

  // Unit status register, sticky flags, bits 5 to 0
  typedef struct packed {
    logic range_wr;
    logic range_rd;
    logic addr1_wr;
    logic addr1_rd;
    logic addr0_wr;
    logic addr0_rd;
  } brk_stat_t;

  // One-hot register select inside a unit, bit 0 is ctl
  typedef struct packed {
    logic addr1;
    logic addr0;
    logic stat;
    logic ctl;
  } brk_sel_t;

endpackage

`default_nettype wire

// ==== verilog/dbg_hwbrk.sv ====
//////////////////////////////////////////////////
// One hardware break/watch-point unit
// Compares data bus or decode pc against its
// addresses, keeps sticky flags, may request halt
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dbg_brk_config.svh"

module dbg_hwbrk (
  input  wire                     dbg_clk,
  input  wire                     dbg_rst,
  input  dbg_brk_pkg::cpu_bus_t   cpu_bus,
  input  wire              [15:0] din,
  input  dbg_brk_pkg::brk_sel_t   brk_wr,
  input  dbg_brk_pkg::brk_sel_t   brk_rd,
  output logic                    brk_halt,
  output logic                    brk_pnd,
  output logic             [15:0] brk_dout
);

  dbg_brk_pkg::brk_ctl_t  brk_ctl;
  dbg_brk_pkg::brk_stat_t brk_stat;
  dbg_brk_pkg::brk_stat_t stat_set;
  logic [15:0]            brk_addr0;
  logic [15:0]            brk_addr1;

  // Address compare results
  logic eq_d_addr0, eq_d_addr1, eq_d_range;
  logic eq_i_addr0, eq_i_addr1, eq_i_range;
  // Qualified accesses
  logic d_wr, d_rd;
  logic mode_rd, mode_wr;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  // Control, range bit kept only with range support
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_ctl <= '0;
    end else if (brk_wr.ctl) begin
      brk_ctl <= {din[4] & `DBG_HWBRK_RANGE, din[3:0]};
    end
  end

  // Status, write-one-to-clear, new set wins over clear
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_stat <= '0;
    end else if (brk_wr.stat) begin
      brk_stat <= (brk_stat & ~din[5:0]) | stat_set;
    end else begin
      brk_stat <= brk_stat | stat_set;
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_addr0 <= '0;
    end else if (brk_wr.addr0) begin
      brk_addr0 <= din;
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_addr1 <= '0;
    end else if (brk_wr.addr1) begin
      brk_addr1 <= din;
    end
  end

  // Read mux, zero when not selected
  always_comb begin
    brk_dout = '0;
    if (brk_rd.ctl)   brk_dout = brk_dout | {11'b0, brk_ctl};
    if (brk_rd.stat)  brk_dout = brk_dout | {10'b0, brk_stat};
    if (brk_rd.addr0) brk_dout = brk_dout | brk_addr0;
    if (brk_rd.addr1) brk_dout = brk_dout | brk_addr1;
  end

  //////////////////////////////////////////////////
  // Comparators
  //////////////////////////////////////////////////

  // Data flow on the execution-unit bus
  assign eq_d_addr0 = cpu_bus.eu_mb_en & (cpu_bus.eu_mab == brk_addr0) & ~brk_ctl.range_mode;
  assign eq_d_addr1 = cpu_bus.eu_mb_en & (cpu_bus.eu_mab == brk_addr1) & ~brk_ctl.range_mode;
  assign eq_d_range = cpu_bus.eu_mb_en & brk_ctl.range_mode & `DBG_HWBRK_RANGE &
                      (cpu_bus.eu_mab >= brk_addr0) & (cpu_bus.eu_mab <= brk_addr1);

  // Instruction flow at decode, interrupts excluded
  assign eq_i_addr0 = cpu_bus.decode_noirq & (cpu_bus.pc == brk_addr0) & ~brk_ctl.range_mode;
  assign eq_i_addr1 = cpu_bus.decode_noirq & (cpu_bus.pc == brk_addr1) & ~brk_ctl.range_mode;
  assign eq_i_range = cpu_bus.decode_noirq & brk_ctl.range_mode & `DBG_HWBRK_RANGE &
                      (cpu_bus.pc >= brk_addr0) & (cpu_bus.pc <= brk_addr1);

  // Data direction, any byte strobe means write
  assign d_wr = ~brk_ctl.inst_en & (|cpu_bus.eu_mb_wr);
  assign d_rd = ~brk_ctl.inst_en & ~(|cpu_bus.eu_mb_wr);

  assign mode_rd = brk_ctl.access_mode[0];
  assign mode_wr = brk_ctl.access_mode[1];

  //////////////////////////////////////////////////
  // Flags and halt
  //////////////////////////////////////////////////

  // Instruction flow only ever counts as a read
  always_comb begin
    stat_set.addr0_rd = mode_rd & ((eq_d_addr0 & d_rd) | (eq_i_addr0 & brk_ctl.inst_en));
    stat_set.addr1_rd = mode_rd & ((eq_d_addr1 & d_rd) | (eq_i_addr1 & brk_ctl.inst_en));
    stat_set.range_rd = mode_rd & ((eq_d_range & d_rd) | (eq_i_range & brk_ctl.inst_en));
    stat_set.addr0_wr = mode_wr & eq_d_addr0 & d_wr;
    stat_set.addr1_wr = mode_wr & eq_d_addr1 & d_wr;
    stat_set.range_wr = mode_wr & eq_d_range & d_wr;
  end

  assign brk_pnd  = |brk_stat;
  // Halt pulse in the cycle of the matched access
  assign brk_halt = brk_ctl.break_en & (|stat_set);

  // A halt request always leaves a flag pending
  a_halt_leaves_pnd: assert property (
    @(posedge dbg_clk) disable iff (dbg_rst) brk_halt |=> brk_pnd
  );

  // Host decode selects one register at a time
  a_wr_onehot: assert property (
    @(posedge dbg_clk) disable iff (dbg_rst) $onehot0(brk_wr)
  );

endmodule

`default_nettype wire

// ==== verilog/dbg_reg_bus.sv ====
//////////////////////////////////////////////////
// Debug register address decode and read combine
// Pure combinational, unmapped addresses read zero
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dbg_brk_config.svh"

module dbg_reg_bus (
  input  dbg_brk_pkg::dbg_req_t dbg_req,
  input  wire            [15:0] brk_dout [`DBG_HWBRK_NUM],
  input  wire            [15:0] stat_dout,
  output dbg_brk_pkg::brk_sel_t brk_wr [`DBG_HWBRK_NUM],
  output dbg_brk_pkg::brk_sel_t brk_rd [`DBG_HWBRK_NUM],
  output logic                  cpu_ctl_wr,
  output logic                  cpu_stat_wr,
  output logic                  cpu_stat_rd,
  output logic           [15:0] dbg_dout
);

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    int unsigned           addr_i;
    dbg_brk_pkg::brk_sel_t sel;
    addr_i = dbg_req.addr;
    // CPU registers
    cpu_ctl_wr  = dbg_req.wr & (dbg_req.addr == `DBG_CPU_CTL);
    cpu_stat_wr = dbg_req.wr & (dbg_req.addr == `DBG_CPU_STAT);
    cpu_stat_rd = dbg_req.rd & (dbg_req.addr == `DBG_CPU_STAT);
    // Unit windows, four-aligned so low bits give the offset
    for (int unsigned n = 0; n < `DBG_HWBRK_NUM; n++) begin
      sel = '0;
      if ((addr_i >= `DBG_BRK_BASE + 4 * n) && (addr_i <= `DBG_BRK_BASE + 4 * n + 3)) begin
        case (dbg_req.addr[1:0])
          `BRK_CTL:   sel.ctl   = 1'b1;
          `BRK_STAT:  sel.stat  = 1'b1;
          `BRK_ADDR0: sel.addr0 = 1'b1;
          `BRK_ADDR1: sel.addr1 = 1'b1;
          default:    sel       = '0;
        endcase
      end
      brk_wr[n] = dbg_req.wr ? sel : '0;
      brk_rd[n] = dbg_req.rd ? sel : '0;
    end
  end

  // Sources are zero unless read, so OR is enough
  always_comb begin
    dbg_dout = stat_dout;
    for (int unsigned n = 0; n < `DBG_HWBRK_NUM; n++) begin
      dbg_dout = dbg_dout | brk_dout[n];
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // No clock here, checked whenever the request settles
  always_comb begin
    int unsigned sel_cnt;
    sel_cnt = 32'(cpu_ctl_wr) + 32'(cpu_stat_wr) + 32'(cpu_stat_rd);
    for (int unsigned n = 0; n < `DBG_HWBRK_NUM; n++) begin
      sel_cnt = sel_cnt + $countones(brk_wr[n]) + $countones(brk_rd[n]);
    end
    if (!$isunknown(dbg_req)) begin
      a_no_wr_rd: assert (!(dbg_req.wr && dbg_req.rd))
        else $error("wr and rd high together");
      a_one_sel: assert (sel_cnt <= 1)
        else $error("more than one register selected");
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dbg_halt_ctl.sv ====
//////////////////////////////////////////////////
// CPU halt control and status for the debug host
// HALT and RUN commands, sticky breakpoint cause
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dbg_brk_config.svh"

module dbg_halt_ctl (
  input  wire        dbg_clk,
  input  wire        dbg_rst,
  input  wire [15:0] din,
  input  wire        cpu_ctl_wr,
  input  wire        cpu_stat_wr,
  input  wire        cpu_stat_rd,
  input  wire        brk_halt_any,
  input  wire        brk_pnd_any,
  output logic       dbg_halt_cmd,
  output logic [15:0] stat_dout
);

  logic halt_set;
  logic run_clr;
  logic brk_halted;
  logic brk_clr;

  //////////////////////////////////////////////////
  // Commands
  //////////////////////////////////////////////////

  // Host HALT or any unit in break mode
  assign halt_set = (cpu_ctl_wr & din[`CPU_CTL_HALT]) | brk_halt_any;
  assign run_clr  = cpu_ctl_wr & din[`CPU_CTL_RUN];
  // Write one to CPU_STAT bit 2 drops the cause
  assign brk_clr  = cpu_stat_wr & din[`CPU_STAT_BRK];

  // Halt request, held until RUN
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_halt_cmd <= 1'b0;
    end else if (halt_set) begin
      dbg_halt_cmd <= 1'b1;
    end else if (run_clr) begin
      dbg_halt_cmd <= 1'b0;
    end
  end

  // Halt caused by a breakpoint
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      brk_halted <= 1'b0;
    end else if (brk_halt_any) begin
      brk_halted <= 1'b1;
    end else if (brk_clr) begin
      brk_halted <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Status read
  //////////////////////////////////////////////////

  always_comb begin
    stat_dout = '0;
    if (cpu_stat_rd) begin
      stat_dout[`CPU_STAT_HALTED] = dbg_halt_cmd;
      stat_dout[`CPU_STAT_PND]    = brk_pnd_any;
      stat_dout[`CPU_STAT_BRK]    = brk_halted;
    end
  end

  // Halt only follows a command or a unit match
  a_halt_cause: assert property (
    @(posedge dbg_clk) disable iff (dbg_rst) $rose(dbg_halt_cmd) |-> $past(halt_set)
  );

endmodule

`default_nettype wire

// ==== verilog/dbg_brk_top.sv ====
//////////////////////////////////////////////////
// Debug break block top level
// Register decode, break units and halt control
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dbg_brk_config.svh"

module dbg_brk_top (
  input  wire                   dbg_clk,
  input  wire                   dbg_rst,
  input  dbg_brk_pkg::dbg_req_t dbg_req,
  input  dbg_brk_pkg::cpu_bus_t cpu_bus,
  output logic           [15:0] dbg_dout,
  output logic                  dbg_halt_cmd
);

  // Per-unit selects and results
  dbg_brk_pkg::brk_sel_t     brk_wr   [`DBG_HWBRK_NUM];
  dbg_brk_pkg::brk_sel_t     brk_rd   [`DBG_HWBRK_NUM];
  logic               [15:0] brk_dout [`DBG_HWBRK_NUM];
  logic [`DBG_HWBRK_NUM-1:0] brk_halt;
  logic [`DBG_HWBRK_NUM-1:0] brk_pnd;

  // CPU register selects
  logic        cpu_ctl_wr;
  logic        cpu_stat_wr;
  logic        cpu_stat_rd;
  logic [15:0] stat_dout;

  dbg_reg_bus u_reg_bus (
    .dbg_req     (dbg_req),
    .brk_dout    (brk_dout),
    .stat_dout   (stat_dout),
    .brk_wr      (brk_wr),
    .brk_rd      (brk_rd),
    .cpu_ctl_wr  (cpu_ctl_wr),
    .cpu_stat_wr (cpu_stat_wr),
    .cpu_stat_rd (cpu_stat_rd),
    .dbg_dout    (dbg_dout)
  );

  // Break units
  for (genvar n = 0; n < `DBG_HWBRK_NUM; n++) begin : g_brk
    dbg_hwbrk u_hwbrk (
      .dbg_clk  (dbg_clk),
      .dbg_rst  (dbg_rst),
      .cpu_bus  (cpu_bus),
      .din      (dbg_req.din),
      .brk_wr   (brk_wr[n]),
      .brk_rd   (brk_rd[n]),
      .brk_halt (brk_halt[n]),
      .brk_pnd  (brk_pnd[n]),
      .brk_dout (brk_dout[n])
    );
  end

  dbg_halt_ctl u_halt_ctl (
    .dbg_clk      (dbg_clk),
    .dbg_rst      (dbg_rst),
    .din          (dbg_req.din),
    .cpu_ctl_wr   (cpu_ctl_wr),
    .cpu_stat_wr  (cpu_stat_wr),
    .cpu_stat_rd  (cpu_stat_rd),
    .brk_halt_any (|brk_halt),
    .brk_pnd_any  (|brk_pnd),
    .dbg_halt_cmd (dbg_halt_cmd),
    .stat_dout    (stat_dout)
  );

endmodule

`default_nettype wire

// ==== verif/dbg_brk_tb.sv ====
//////////////////////////////////////////////////
// Directed testbench for the debug break block
// Drives the host register port and the CPU bus,
// checks read data, sticky flags and halt request
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dbg_brk_config.svh"

module dbg_brk_tb;

  logic                  dbg_clk;
  logic                  dbg_rst;
  dbg_brk_pkg::dbg_req_t dbg_req;
  dbg_brk_pkg::cpu_bus_t cpu_bus;
  logic           [15:0] dbg_dout;
  logic                  dbg_halt_cmd;

  int          mismatch_cnt;
  int          timeout_cnt;
  logic [15:0] lfsr_state;

  dbg_brk_top dut (
    .dbg_clk      (dbg_clk),
    .dbg_rst      (dbg_rst),
    .dbg_req      (dbg_req),
    .cpu_bus      (cpu_bus),
    .dbg_dout     (dbg_dout),
    .dbg_halt_cmd (dbg_halt_cmd)
  );

  // 100 ns period
  always #50 dbg_clk = ~dbg_clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] nxt;
    nxt = s >> 1;
    if (s[0]) nxt = nxt ^ 16'hB400;
    return nxt;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output logic [15:0] w);
    w = '0;
    for (int i = 0; i < 16; i++) begin
      w = {w[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Register address inside a unit window
  function automatic logic [`DBG_ADDR_W-1:0] unit_reg_addr(input int n, input logic [1:0] off);
    logic [31:0] a;
    a = `DBG_BRK_BASE + 4 * n + off;
    return a[`DBG_ADDR_W-1:0];
  endfunction

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_ctl(input string name, input dbg_brk_pkg::brk_ctl_t exp,
                           input dbg_brk_pkg::brk_ctl_t act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_stat(input string name, input dbg_brk_pkg::brk_stat_t exp,
                            input dbg_brk_pkg::brk_stat_t act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %b actual %b", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  // Write lands on the second edge, request idles there
  task automatic reg_write(input logic [`DBG_ADDR_W-1:0] addr, input logic [15:0] data);
    dbg_brk_pkg::dbg_req_t req;
    req      = '0;
    req.addr = addr;
    req.din  = data;
    req.wr   = 1'b1;
    @(posedge dbg_clk);
    dbg_req <= req;
    @(posedge dbg_clk);
    dbg_req <= '0;
  endtask

  // Read data is combinational, sampled mid-cycle
  task automatic reg_read(input logic [`DBG_ADDR_W-1:0] addr, output logic [15:0] data);
    dbg_brk_pkg::dbg_req_t req;
    req      = '0;
    req.addr = addr;
    req.rd   = 1'b1;
    @(posedge dbg_clk);
    dbg_req <= req;
    @(negedge dbg_clk);
    data = dbg_dout;
    @(posedge dbg_clk);
    dbg_req <= '0;
  endtask

  // One cycle of bus or decode activity
  task automatic cpu_access(input logic [15:0] mab, input logic mb_en, input logic [1:0] mb_wr,
                            input logic [15:0] pc, input logic noirq);
    dbg_brk_pkg::cpu_bus_t bus;
    bus              = '0;
    bus.eu_mab       = mab;
    bus.eu_mb_en     = mb_en;
    bus.eu_mb_wr     = mb_wr;
    bus.pc           = pc;
    bus.decode_noirq = noirq;
    @(posedge dbg_clk);
    cpu_bus <= bus;
    @(posedge dbg_clk);
    cpu_bus <= '0;
  endtask

  task automatic unit_stat_expect(input int n, input dbg_brk_pkg::brk_stat_t exp);
    logic [15:0] rd;
    reg_read(unit_reg_addr(n, `BRK_STAT), rd);
    check_stat($sformatf("unit%0d stat", n), exp, rd[5:0]);
    check_word($sformatf("unit%0d stat upper bits", n), 16'h0000, rd & 16'hFFC0);
  endtask

  task automatic cpu_stat_expect(input logic [15:0] exp);
    logic [15:0] rd;
    reg_read(`DBG_CPU_STAT, rd);
    check_word("cpu_stat", exp, rd);
  endtask

  // Bounded wait for the halt request level
  task automatic wait_halt_level(input logic exp, input int max_cycles);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < max_cycles && !seen; i++) begin
      @(negedge dbg_clk);
      seen = (dbg_halt_cmd === exp);
    end
    if (!seen) begin
      $display("Timeout at time %0t: dbg_halt_cmd did not reach %b within %0d cycles",
               $time, exp, max_cycles);
      timeout_cnt++;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic reg_access_test();
    logic [15:0] val;
    logic [15:0] rd;
    logic [5:0]  unmapped [4];
    unmapped = '{6'h02, 6'h07, 6'(`DBG_BRK_BASE + 4 * `DBG_HWBRK_NUM), 6'h3F};
    for (int n = 0; n < `DBG_HWBRK_NUM; n++) begin
      // All ones, only the five control bits stick
      reg_write(unit_reg_addr(n, `BRK_CTL), 16'hFFFF);
      reg_read(unit_reg_addr(n, `BRK_CTL), rd);
      check_ctl($sformatf("unit%0d ctl", n), {`DBG_HWBRK_RANGE, 4'hF}, rd[4:0]);
      check_word($sformatf("unit%0d ctl upper bits", n), 16'h0000, rd & 16'hFFE0);
      reg_write(unit_reg_addr(n, `BRK_CTL), 16'h0000);
      reg_read(unit_reg_addr(n, `BRK_CTL), rd);
      check_ctl($sformatf("unit%0d ctl", n), 5'h00, rd[4:0]);
      rand_word(val);
      reg_write(unit_reg_addr(n, `BRK_ADDR0), val);
      reg_read(unit_reg_addr(n, `BRK_ADDR0), rd);
      check_word($sformatf("unit%0d addr0", n), val, rd);
      rand_word(val);
      reg_write(unit_reg_addr(n, `BRK_ADDR1), val);
      reg_read(unit_reg_addr(n, `BRK_ADDR1), rd);
      check_word($sformatf("unit%0d addr1", n), val, rd);
    end
    foreach (unmapped[i]) begin
      reg_read(unmapped[i], rd);
      check_word($sformatf("dbg_dout at 0x%h", unmapped[i]), 16'h0000, rd);
    end
  endtask

  // Unit 0 watches data writes, no break
  task automatic data_watch_test();
    dbg_brk_pkg::brk_stat_t exp;
    reg_write(unit_reg_addr(0, `BRK_ADDR0), 16'h1234);
    reg_write(unit_reg_addr(0, `BRK_ADDR1), 16'h5678);
    reg_write(unit_reg_addr(0, `BRK_CTL), 16'h0002);
    cpu_access(16'h1234, 1'b1, 2'b11, 16'h0000, 1'b0);
    exp = '0;
    exp.addr0_wr = 1'b1;
    unit_stat_expect(0, exp);
    cpu_stat_expect(16'h0001 << `CPU_STAT_PND);
    @(negedge dbg_clk);
    check_bit("dbg_halt_cmd", 1'b0, dbg_halt_cmd);
    // Read of a watched address in write mode
    cpu_access(16'h1234, 1'b1, 2'b00, 16'h0000, 1'b0);
    unit_stat_expect(0, exp);
    // Byte write to addr1 for the clear test
    cpu_access(16'h5678, 1'b1, 2'b01, 16'h0000, 1'b0);
    exp.addr1_wr = 1'b1;
    unit_stat_expect(0, exp);
    @(negedge dbg_clk);
    check_bit("dbg_halt_cmd", 1'b0, dbg_halt_cmd);
  endtask

  task automatic stat_clear_test();
    dbg_brk_pkg::brk_stat_t exp;
    exp = '0;
    exp.addr1_wr = 1'b1;
    reg_write(unit_reg_addr(0, `BRK_STAT), 16'h0002);
    unit_stat_expect(0, exp);
    cpu_stat_expect(16'h0001 << `CPU_STAT_PND);
    reg_write(unit_reg_addr(0, `BRK_STAT), 16'h0008);
    unit_stat_expect(0, 6'h00);
    cpu_stat_expect(16'h0000);
    reg_write(unit_reg_addr(0, `BRK_CTL), 16'h0000);
  endtask

  // Unit 1 breaks on decode reads
  task automatic inst_break_test();
    dbg_brk_pkg::brk_stat_t exp;
    reg_write(unit_reg_addr(1, `BRK_ADDR0), 16'hC010);
    reg_write(unit_reg_addr(1, `BRK_ADDR1), 16'hC020);
    reg_write(unit_reg_addr(1, `BRK_CTL), 16'h000D);
    // Interrupt entry is not a decode
    cpu_access(16'h0000, 1'b0, 2'b00, 16'hC010, 1'b0);
    unit_stat_expect(1, 6'h00);
    @(negedge dbg_clk);
    check_bit("dbg_halt_cmd", 1'b0, dbg_halt_cmd);
    cpu_access(16'h0000, 1'b0, 2'b00, 16'hC010, 1'b1);
    wait_halt_level(1'b1, 1);
    exp = '0;
    exp.addr0_rd = 1'b1;
    unit_stat_expect(1, exp);
    cpu_stat_expect(16'h0007);
    reg_write(`DBG_CPU_CTL, 16'h0001 << `CPU_CTL_RUN);
    wait_halt_level(1'b0, 1);
    cpu_stat_expect(16'h0006);
    // Drop the cause, the flags and the unit setup
    reg_write(`DBG_CPU_STAT, 16'h0001 << `CPU_STAT_BRK);
    reg_write(unit_reg_addr(1, `BRK_STAT), 16'h003F);
    reg_write(unit_reg_addr(1, `BRK_CTL), 16'h0000);
    cpu_stat_expect(16'h0000);
  endtask

  // Inclusive range on data reads
  task automatic range_mode_test();
    dbg_brk_pkg::brk_stat_t exp;
    logic [15:0] lo;
    logic [15:0] hi;
    logic [15:0] a;
    lo = 16'h3000;
    hi = 16'hA000;
    reg_write(unit_reg_addr(0, `BRK_ADDR0), lo);
    reg_write(unit_reg_addr(0, `BRK_ADDR1), hi);
    reg_write(unit_reg_addr(0, `BRK_CTL), 16'h0011);
    for (int i = 0; i < 16; i++) begin
      // Bounds and their neighbours first
      case (i)
        0:       a = lo;
        1:       a = hi;
        2:       a = lo - 16'd1;
        3:       a = hi + 16'd1;
        default: rand_word(a);
      endcase
      reg_write(unit_reg_addr(0, `BRK_STAT), 16'h003F);
      cpu_access(a, 1'b1, 2'b00, 16'h0000, 1'b0);
      exp = '0;
      exp.range_rd = (a >= lo) && (a <= hi) && `DBG_HWBRK_RANGE;
      unit_stat_expect(0, exp);
    end
    reg_write(unit_reg_addr(0, `BRK_CTL), 16'h0000);
    reg_write(unit_reg_addr(0, `BRK_STAT), 16'h003F);
    @(negedge dbg_clk);
    check_bit("dbg_halt_cmd", 1'b0, dbg_halt_cmd);
  endtask

  task automatic host_cmd_test();
    reg_write(`DBG_CPU_CTL, 16'h0001 << `CPU_CTL_HALT);
    wait_halt_level(1'b1, 1);
    cpu_stat_expect(16'h0001 << `CPU_STAT_HALTED);
    reg_write(`DBG_CPU_CTL, 16'h0001 << `CPU_CTL_RUN);
    wait_halt_level(1'b0, 1);
    cpu_stat_expect(16'h0000);
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    dbg_clk      = 1'b0;
    dbg_rst      = 1'b1;
    dbg_req      = '0;
    cpu_bus      = '0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    lfsr_state   = 16'd7611;
    repeat (16) @(posedge dbg_clk);
    dbg_rst <= 1'b0;
    @(negedge dbg_clk);
    check_bit("dbg_halt_cmd after reset", 1'b0, dbg_halt_cmd);
    check_word("dbg_dout after reset", 16'h0000, dbg_dout);
    reg_access_test();
    data_watch_test();
    stat_clear_test();
    inst_break_test();
    range_mode_test();
    host_cmd_test();
    $display("Errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dbg_brk.f ====
+incdir+verilog
verilog/dbg_brk_pkg.sv
verilog/dbg_hwbrk.sv
verilog/dbg_reg_bus.sv
verilog/dbg_halt_ctl.sv
verilog/dbg_brk_top.sv
verif/dbg_brk_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the debug break block testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dbg_brk_tb -Mdir obj_dir -f dbg_brk.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vdbg_brk_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '** PASS **'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
